// File: common/booth_defines.svh
`ifndef BOOTH_DEFINES_SVH
`define BOOTH_DEFINES_SVH

// **************************************************
// operand and counter sizing for the Booth multiplier
// **************************************************

// width of each signed operand in bits.
`define BOOTH_WIDTH 8

// the product carries twice the operand width.
`define BOOTH_PROD_WIDTH (2 * `BOOTH_WIDTH)

// the step counter has to reach BOOTH_WIDTH itself, so it needs one bit more
// than log2 of the width when the width is a power of two.
`define BOOTH_CNT_WIDTH 4

`endif

// File: common/booth_ctrl_pkg.sv
package booth_ctrl_pkg;

    // **************************************************
    // controller state encoding
    // **************************************************

    // the reset state sits at 2'b11 so that a cleared register is already idle
    // and only the reset path ever visits RESET.
    typedef enum logic [1:0] {
        IDLE  = 2'b00,   // waiting for an operand pair.
        RUN   = 2'b01,   // one Booth step per clock.
        DONE  = 2'b10,   // product held for the consumer.
        RESET = 2'b11    // one cycle after reset is released.
    } ctrl_state_t;

    // **************************************************
    // Booth step operation
    // **************************************************

    // what happens to the accumulator before the shift.
    typedef enum logic [1:0] {
        OP_NONE = 2'b00,  // bit pair 00 or 11.
        OP_ADD  = 2'b01,  // bit pair 01, end of a run of ones.
        OP_SUB  = 2'b10   // bit pair 10, start of a run of ones.
    } booth_op_t;

endpackage

// File: common/booth_data_pkg.sv
`include "booth_defines.svh"

package booth_data_pkg;

    // **************************************************
    // datapath payload types
    // **************************************************

    // one signed operand, used for both multiplicand and multiplier.
    typedef logic signed [`BOOTH_WIDTH-1:0] operand_t;

    // the full two's-complement product.
    typedef logic signed [`BOOTH_PROD_WIDTH-1:0] product_t;

    // The accumulator is one bit wider than an operand. Subtracting the most
    // negative multiplicand would otherwise overflow before the shift.
    typedef logic signed [`BOOTH_WIDTH:0] acc_t;

endpackage

// File: common/booth_step_if.sv
// step control between the Booth controller and the datapath.
interface booth_step_if;

    // **************************************************
    // controller to datapath
    // **************************************************

    logic load;                      // capture operands and clear the step state.
    logic step;                      // perform one Booth step on this edge.
    booth_ctrl_pkg::booth_op_t op;   // add, subtract or skip the multiplicand.

    // **************************************************
    // datapath to controller
    // **************************************************

    logic [1:0] q_pair;              // low multiplier bit and guard bit.
    logic count_done;                // all steps have been performed.

    modport ctrl (
        output load,
        output step,
        output op,
        input  q_pair,
        input  count_done
    );

    modport dp (
        input  load,
        input  step,
        input  op,
        output q_pair,
        output count_done
    );

endinterface

// File: booth/booth_controller.sv
module booth_controller (
    input  logic       clk,
    input  logic       rst,
    input  logic       src_val,
    output logic       src_ready,
    output logic       dest_val,
    input  logic       dest_ready,
    booth_step_if.ctrl step_bus
);

    booth_ctrl_pkg::ctrl_state_t state;
    booth_ctrl_pkg::ctrl_state_t next_state;
    booth_ctrl_pkg::booth_op_t   decoded_op;

    // **************************************************
    // state register
    // **************************************************

    always_ff @(posedge clk or negedge rst)
    begin
        if (!rst)
        begin
            state <= booth_ctrl_pkg::RESET;
        end
        else
        begin
            state <= next_state;
        end
    end

    // **************************************************
    // next state, handshake and strobes
    // **************************************************

    always_comb
    begin
        next_state    = state;
        src_ready     = 1'b0;
        dest_val      = 1'b0;
        step_bus.load = 1'b0;
        step_bus.step = 1'b0;

        case (state)
            booth_ctrl_pkg::RESET:
            begin
                next_state = booth_ctrl_pkg::IDLE;
            end

            booth_ctrl_pkg::IDLE:
            begin
                src_ready     = 1'b1;
                step_bus.load = src_val;   // the accepting edge loads the operands.
                if (src_val)
                begin
                    next_state = booth_ctrl_pkg::RUN;
                end
            end

            booth_ctrl_pkg::RUN:
            begin
                // The last step raises count_done on its own edge. The product is
                // then already valid, so it is offered without waiting for DONE.
                if (!step_bus.count_done)
                begin
                    step_bus.step = 1'b1;
                end
                else
                begin
                    dest_val   = 1'b1;
                    next_state = dest_ready ? booth_ctrl_pkg::IDLE : booth_ctrl_pkg::DONE;
                end
            end

            booth_ctrl_pkg::DONE:
            begin
                dest_val = 1'b1;   // held until the consumer takes it.
                if (dest_ready)
                begin
                    next_state = booth_ctrl_pkg::IDLE;
                end
            end

            default:
            begin
                next_state = booth_ctrl_pkg::RESET;
            end
        endcase
    end

    // **************************************************
    // Booth recoding of the bit pair
    // **************************************************

    always_comb
    begin
        case (step_bus.q_pair)
            2'b01:   decoded_op = booth_ctrl_pkg::OP_ADD;
            2'b10:   decoded_op = booth_ctrl_pkg::OP_SUB;
            default: decoded_op = booth_ctrl_pkg::OP_NONE;
        endcase
    end

    // outside a step the datapath sees no operation at all.
    assign step_bus.op = step_bus.step ? decoded_op : booth_ctrl_pkg::OP_NONE;

    // a product on offer must not be withdrawn before it is taken.
    dest_val_held: assert property (
        @(posedge clk) disable iff (!rst)
        (dest_val && !dest_ready) |=> dest_val
    );

    // loading in the middle of a step would corrupt the accumulator.
    load_step_exclusive: assert property (
        @(posedge clk) disable iff (!rst)
        !(step_bus.load && step_bus.step)
    );

endmodule

// File: booth/booth_datapath.sv
`include "booth_defines.svh"

module booth_datapath (
    input  logic                     clk,
    input  logic                     rst,
    input  booth_data_pkg::operand_t multiplicand,
    input  booth_data_pkg::operand_t multiplier,
    output booth_data_pkg::product_t product,
    booth_step_if.dp                 step_bus
);

    localparam logic [`BOOTH_CNT_WIDTH-1:0] last_count = `BOOTH_WIDTH;

    // payload registers.
    booth_data_pkg::operand_t mcand_q;
    booth_data_pkg::operand_t mplr_q;
    booth_data_pkg::acc_t     acc_q;
    logic                     guard_q;

    // step bookkeeping.
    logic [`BOOTH_CNT_WIDTH-1:0] count_q;
    logic [`BOOTH_CNT_WIDTH-1:0] count_next;
    logic                        count_done_q;

    // one step worth of combinational work.
    booth_data_pkg::acc_t               mcand_ext;
    booth_data_pkg::acc_t               acc_sum;
    logic signed [2*`BOOTH_WIDTH+1:0]   pair_sum;
    logic signed [2*`BOOTH_WIDTH+1:0]   pair_shifted;

    // **************************************************
    // add or subtract, then arithmetic shift
    // **************************************************

    assign mcand_ext = {mcand_q[`BOOTH_WIDTH-1], mcand_q};   // sign extension.

    always_comb
    begin
        case (step_bus.op)
            booth_ctrl_pkg::OP_ADD: acc_sum = acc_q + mcand_ext;
            booth_ctrl_pkg::OP_SUB: acc_sum = acc_q - mcand_ext;
            default:                acc_sum = acc_q;
        endcase
    end

    // The whole {A, Q, guard} chain moves right by one. The sign of A is copied in
    // from the top, and the old Q[0] drops into the guard bit.
    assign pair_sum     = {acc_sum, mplr_q, guard_q};
    assign pair_shifted = pair_sum >>> 1;

    always_ff @(posedge clk)
    begin
        if (step_bus.load)
        begin
            mcand_q <= multiplicand;
            mplr_q  <= multiplier;
            acc_q   <= '0;
            guard_q <= 1'b0;
        end
        else if (step_bus.step)
        begin
            {acc_q, mplr_q, guard_q} <= pair_shifted;
        end
    end

    // **************************************************
    // step counter
    // **************************************************

    assign count_next = count_q + {{(`BOOTH_CNT_WIDTH-1){1'b0}}, 1'b1};

    always_ff @(posedge clk or negedge rst)
    begin
        if (!rst)
        begin
            count_q      <= '0;
            count_done_q <= 1'b0;
        end
        else if (step_bus.load)
        begin
            count_q      <= '0;
            count_done_q <= 1'b0;
        end
        else if (step_bus.step)
        begin
            count_q      <= count_next;
            count_done_q <= (count_next == last_count);   // set by the last step.
        end
    end

    // **************************************************
    // outputs
    // **************************************************

    // the spare top bit of A is only a copy of the sign by now.
    assign product = {acc_q[`BOOTH_WIDTH-1:0], mplr_q};

    assign step_bus.q_pair     = {mplr_q[0], guard_q};
    assign step_bus.count_done = count_done_q;

    // the controller must stop stepping once the counter has run out.
    no_step_after_done: assert property (
        @(posedge clk) disable iff (!rst)
        step_bus.step |-> !count_done_q
    );

endmodule

// File: hw/booth_multiplier_top.sv
module booth_multiplier_top (
    input  logic                     clk,
    input  logic                     rst,

    // operand side.
    input  logic                     src_val,
    output logic                     src_ready,
    input  booth_data_pkg::operand_t multiplicand,
    input  booth_data_pkg::operand_t multiplier,

    // product side.
    output logic                     dest_val,
    input  logic                     dest_ready,
    output booth_data_pkg::product_t product
);

    // **************************************************
    // controller to datapath link
    // **************************************************

    booth_step_if step_bus ();

    // sequencing and handshake.
    booth_controller u_ctrl (
        .clk        (clk),
        .rst        (rst),
        .src_val    (src_val),
        .src_ready  (src_ready),
        .dest_val   (dest_val),
        .dest_ready (dest_ready),
        .step_bus   (step_bus.ctrl)
    );

    // registers, adder and shifter.
    booth_datapath u_dp (
        .clk          (clk),
        .rst          (rst),
        .multiplicand (multiplicand),
        .multiplier   (multiplier),
        .product      (product),
        .step_bus     (step_bus.dp)
    );

endmodule

// File: tests/tb_booth_multiplier.sv
`include "booth_defines.svh"

module tb_booth_multiplier;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int wait_limit = 4 * `BOOTH_WIDTH;
    localparam booth_data_pkg::operand_t op_zero = '0;
    localparam booth_data_pkg::operand_t op_one = booth_data_pkg::operand_t'(1);
    localparam booth_data_pkg::operand_t op_neg_one = '1;
    localparam booth_data_pkg::operand_t op_min = {1'b1, {(`BOOTH_WIDTH-1){1'b0}}};
    localparam booth_data_pkg::operand_t op_max = {1'b0, {(`BOOTH_WIDTH-1){1'b1}}};

    logic                     clk;
    logic                     rst;
    logic                     src_val;
    logic                     src_ready;
    logic                     dest_val;
    logic                     dest_ready;
    booth_data_pkg::operand_t multiplicand;
    booth_data_pkg::operand_t multiplier;
    booth_data_pkg::product_t product;

    logic [31:0] lfsr_state;
    int          checks;
    int          errors;
    int          timeouts;

    booth_multiplier_top dut (
        .clk          (clk),
        .rst          (rst),
        .src_val      (src_val),
        .src_ready    (src_ready),
        .multiplicand (multiplicand),
        .multiplier   (multiplier),
        .dest_val     (dest_val),
        .dest_ready   (dest_ready),
        .product      (product)
    );

    initial
    begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // **************************************************
    // stimulus source and reference model
    // **************************************************

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        logic [31:0] n;
        n = s >> 1;
        if (s[0])
        begin
            n = n ^ 32'h8020_0003;   // taps 32, 22, 2 and 1.
        end
        return n;
    endfunction

    task automatic draw_bits(input int count, output logic [31:0] bits);
        bits = '0;
        for (int i = 0; i < count; i++)
        begin
            lfsr_state = lfsr_step(lfsr_state);
            bits = {bits[30:0], lfsr_state[0]};
        end
    endtask

    task automatic random_operand(output booth_data_pkg::operand_t value);
        logic [31:0] bits;
        draw_bits(`BOOTH_WIDTH, bits);
        value = booth_data_pkg::operand_t'(bits[`BOOTH_WIDTH-1:0]);
    endtask

    // plain integer multiply, truncated to the product width.
    function automatic booth_data_pkg::product_t reference_product(
        input booth_data_pkg::operand_t a,
        input booth_data_pkg::operand_t b
    );
        int wide;
        wide = int'(a) * int'(b);
        return booth_data_pkg::product_t'(wide);
    endfunction

    task automatic compare_product(input string name, input booth_data_pkg::product_t expected,
                                   input booth_data_pkg::product_t actual);
        checks++;
        assert (actual == expected) else
        begin
            $display("[ERROR] %s: product expected %0d, actual %0d", name, expected, actual);
            errors++;
        end
    endtask

    task automatic compare_bit(input string name, input string what, input logic expected,
                               input logic actual);
        checks++;
        assert (actual === expected) else
        begin
            $display("[ERROR] %s: %s expected %0b, actual %0b", name, what, expected, actual);
            errors++;
        end
    endtask

    task automatic compare_count(input string name, input string what, input int expected,
                                 input int actual);
        checks++;
        assert (actual == expected) else
        begin
            $display("[ERROR] %s: %s expected %0d, actual %0d", name, what, expected, actual);
            errors++;
        end
    endtask

    // **************************************************
    // handshake helpers
    // **************************************************

    task automatic await_src_ready(input string name, output bit ok);
        int cycles;
        cycles = 0;
        while (src_ready !== 1'b1 && cycles < wait_limit)
        begin
            @(posedge clk);
            #1;
            cycles++;
        end
        ok = (src_ready === 1'b1);
        if (!ok)
        begin
            $display("%s: src_ready did not rise within %0d cycles.", name, wait_limit);
            timeouts++;
        end
    endtask

    // one full operation from the accepting edge to the consuming edge.
    task automatic multiply_once(input string name, input booth_data_pkg::operand_t a,
                                 input booth_data_pkg::operand_t b, input bit hold_ready,
                                 input int stall, input bit pulse_busy, output bit ok);
        int cycles;
        dest_ready = hold_ready;
        await_src_ready(name, ok);
        if (!ok)
        begin
            return;
        end
        multiplicand = a;
        multiplier   = b;
        src_val      = 1'b1;
        @(posedge clk);
        #1;
        src_val = 1'b0;   // accepted on that edge.
        cycles  = 0;
        while (dest_val !== 1'b1 && cycles < wait_limit)
        begin
            compare_bit(name, "src_ready while busy", 1'b0, src_ready);
            if (pulse_busy && cycles == 2)
            begin
                src_val      = 1'b1;   // must be ignored during RUN.
                multiplicand = ~a;
                multiplier   = ~b;
            end
            else
            begin
                src_val = 1'b0;
            end
            @(posedge clk);
            #1;
            cycles++;
        end
        src_val = 1'b0;
        if (dest_val !== 1'b1)
        begin
            $display("%s: dest_val did not rise within %0d cycles.", name, wait_limit);
            timeouts++;
            ok = 1'b0;
            return;
        end
        compare_count(name, "latency", `BOOTH_WIDTH, cycles);
        compare_product(name, reference_product(a, b), product);
        if (!hold_ready)
        begin
            for (int i = 0; i < stall; i++)
            begin
                @(posedge clk);
                #1;
                compare_bit(name, "dest_val under back-pressure", 1'b1, dest_val);
                compare_product(name, reference_product(a, b), product);
            end
            dest_ready = 1'b1;
        end
        @(posedge clk);
        #1;
        dest_ready = hold_ready;
        compare_bit(name, "dest_val after consume", 1'b0, dest_val);
        compare_bit(name, "src_ready after consume", 1'b1, src_ready);
    endtask

    // **************************************************
    // directed tests
    // **************************************************

    task automatic reset_sequence();
        for (int i = 0; i < 4; i++)
        begin
            @(posedge clk);
            #1;
            compare_bit("reset_sequence", "src_ready in reset", 1'b0, src_ready);
            compare_bit("reset_sequence", "dest_val in reset", 1'b0, dest_val);
        end
        rst = 1'b1;
        compare_bit("reset_sequence", "src_ready first cycle", 1'b0, src_ready);
        compare_bit("reset_sequence", "dest_val first cycle", 1'b0, dest_val);
        @(posedge clk);
        #1;
        compare_bit("reset_sequence", "src_ready second cycle", 1'b1, src_ready);
    endtask

    task automatic corner_products();
        booth_data_pkg::operand_t r;
        bit                       ok;
        random_operand(r);
        multiply_once("corner_products", op_zero, r, 1'b1, 0, 1'b0, ok);
        multiply_once("corner_products", r, op_zero, 1'b1, 0, 1'b0, ok);
        multiply_once("corner_products", op_one, op_neg_one, 1'b1, 0, 1'b0, ok);
        multiply_once("corner_products", op_min, op_min, 1'b1, 0, 1'b0, ok);
        multiply_once("corner_products", op_min, op_max, 1'b1, 0, 1'b0, ok);
        multiply_once("corner_products", op_max, op_max, 1'b1, 0, 1'b0, ok);
        multiply_once("corner_products", op_neg_one, op_neg_one, 1'b1, 0, 1'b0, ok);
    endtask

    task automatic random_products();
        booth_data_pkg::operand_t a;
        booth_data_pkg::operand_t b;
        bit                       ok;
        for (int i = 0; i < 40; i++)
        begin
            random_operand(a);
            random_operand(b);
            multiply_once("random_products", a, b, 1'b1, 0, 1'b0, ok);
            if (!ok)
            begin
                return;
            end
        end
    endtask

    // latency is checked with the consumer not yet ready.
    task automatic latency_measure();
        booth_data_pkg::operand_t a;
        booth_data_pkg::operand_t b;
        bit                       ok;
        for (int i = 0; i < 4; i++)
        begin
            random_operand(a);
            random_operand(b);
            multiply_once("latency_measure", a, b, 1'b0, 0, 1'b0, ok);
        end
    endtask

    task automatic back_pressure();
        booth_data_pkg::operand_t a;
        booth_data_pkg::operand_t b;
        logic [31:0]              bits;
        bit                       ok;
        for (int i = 0; i < 8; i++)
        begin
            random_operand(a);
            random_operand(b);
            draw_bits(4, bits);
            multiply_once("back_pressure", a, b, 1'b0, int'(bits[3:0]), 1'b0, ok);
        end
    endtask

    task automatic busy_window();
        booth_data_pkg::operand_t a;
        booth_data_pkg::operand_t b;
        bit                       ok;
        for (int i = 0; i < 4; i++)
        begin
            random_operand(a);
            random_operand(b);
            multiply_once("busy_window", a, b, 1'b1, 0, 1'b1, ok);
        end
    endtask

    initial
    begin
        rst          = 1'b0;
        src_val      = 1'b0;
        dest_ready   = 1'b0;
        multiplicand = '0;
        multiplier   = '0;
        lfsr_state   = 32'ha500_07d2;
        checks       = 0;
        errors       = 0;
        timeouts     = 0;

        reset_sequence();
        corner_products();
        random_products();
        latency_measure();
        back_pressure();
        busy_window();

        $display("checks %0d, errors %0d, timeouts %0d", checks, errors, timeouts);
        if (errors == 0 && timeouts == 0)
        begin
            $display("Simulation passed");
        end
        else
        begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// File: sim.f
+incdir+common
common/booth_ctrl_pkg.sv
common/booth_data_pkg.sv
common/booth_step_if.sv
booth/booth_controller.sv
booth/booth_datapath.sv
hw/booth_multiplier_top.sv
tests/tb_booth_multiplier.sv

// File: run_sim.sh
#!/bin/sh
# Compile and run the Booth multiplier testbench with Verilator.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module tb_booth_multiplier -f sim.f -o tb_booth_multiplier

status=0
./obj_dir/tb_booth_multiplier > sim.log 2>&1 || status=$?
cat sim.log

if [ "$status" -ne 0 ]; then
    echo "simulator exited with status $status"
    exit 1
fi
if grep -q "Simulation failed" sim.log; then
    exit 1
fi
grep -q "Simulation passed" sim.log
exit 0
